// File: source/tinker_pkg.sv
package tinker_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    // kept Tinker opcodes, everything else decodes as a no-op
    typedef enum logic [4:0] {
        op_and     = 5'b00000,
        op_or      = 5'b00001,
        op_xor     = 5'b00010,
        op_not     = 5'b00011,
        op_shftr   = 5'b00100,
        op_shftri  = 5'b00101,
        op_shftl   = 5'b00110,
        op_shftli  = 5'b00111,
        op_jump    = 5'b01000,
        op_brr_rd  = 5'b01001,
        op_brr_lit = 5'b01010,
        op_brnz    = 5'b01011,
        op_brgt    = 5'b01110,
        op_halt    = 5'b01111,
        op_load    = 5'b10000,
        op_mov_rr  = 5'b10001,
        op_mov_lit = 5'b10010,
        op_store   = 5'b10011,
        op_add     = 5'b11000,
        op_addi    = 5'b11001,
        op_sub     = 5'b11010,
        op_subi    = 5'b11011
    } opcode_t;

    localparam word_t reset_pc    = 64'h2000;
    localparam word_t instr_bytes = 64'd4;
    localparam int    num_regs    = 32;

    // operand source selects
    localparam logic [1:0] fwd_none = 2'd0;  // register file value
    localparam logic [1:0] fwd_mem  = 2'd1;  // EX/MEM result
    localparam logic [1:0] fwd_wb   = 2'd2;  // MEM/WB value

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fetch_stage_t;

    typedef struct packed {
        word_t    pc;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     uses_rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    rd_val;
        word_t    literal;  // already sign extended
    } decode_stage_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    result;
        addr_t    address;
        word_t    store_data;
    } mem_stage_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        word_t    value;
    } wb_stage_t;

endpackage

// File: source/tinker_stage_reg.sv
`timescale 1ns/100ps

module tinker_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= flush ? 1'b0 : in_valid;
        end
    end

    // payload follows valid, bubbles just carry stale data
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // the core masks a redirect flush while memory stalls, so hold always wins
    a_no_flush_on_hold: assert property (
        @(posedge clk) disable iff (reset) flush |-> !hold
    );

endmodule

// File: source/tinker_decoder.sv
`timescale 1ns/100ps

module tinker_decoder (
    input  tinker_pkg::instr_t   instr,
    output tinker_pkg::opcode_t  opcode,
    output tinker_pkg::reg_idx_t rd,
    output tinker_pkg::reg_idx_t rs,
    output tinker_pkg::reg_idx_t rt,
    output tinker_pkg::word_t    literal,
    output logic                 uses_rt,
    output logic                 is_halt
);

    import tinker_pkg::*;

    imm_t lit_field;

    assign opcode    = opcode_t'(instr[31:27]);  // unknown codes pass through
    assign rd        = instr[26:22];
    assign rs        = instr[21:17];
    assign rt        = instr[16:12];
    assign lit_field = instr[11:0];
    assign literal   = {{52{lit_field[11]}}, lit_field};

    assign is_halt = (opcode == op_halt);

    // forms that take the literal in place of rt
    always_comb begin
        case (opcode)
            op_addi,
            op_subi,
            op_shftri,
            op_shftli,
            op_mov_lit,
            op_brr_lit,
            op_load,
            op_store: uses_rt = 1'b0;
            default:  uses_rt = 1'b1;
        endcase
    end

endmodule

// File: source/tinker_regfile.sv
`timescale 1ns/100ps

module tinker_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_en,
    input  tinker_pkg::reg_idx_t write_idx,
    input  tinker_pkg::word_t    write_data,
    input  tinker_pkg::reg_idx_t read_rs,
    input  tinker_pkg::reg_idx_t read_rt,
    input  tinker_pkg::reg_idx_t read_rd,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val,
    output tinker_pkg::word_t    rd_val
);

    import tinker_pkg::*;

    word_t regs [num_regs];  // r0 is an ordinary register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    // writeback in the same cycle reaches decode directly
    assign rs_val = (write_en && write_idx == read_rs) ? write_data : regs[read_rs];
    assign rt_val = (write_en && write_idx == read_rt) ? write_data : regs[read_rt];
    assign rd_val = (write_en && write_idx == read_rd) ? write_data : regs[read_rd];

endmodule

// File: source/tinker_hazard.sv
`timescale 1ns/100ps

module tinker_hazard (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ex_valid,
    input  tinker_pkg::reg_idx_t ex_rs,
    input  tinker_pkg::reg_idx_t ex_rt,
    input  tinker_pkg::reg_idx_t ex_rd,
    input  logic                 ex_uses_rt,
    input  logic                 ex_is_load,
    input  tinker_pkg::reg_idx_t mem_rd,
    input  logic                 mem_reg_write,
    input  logic                 mem_is_load,
    input  tinker_pkg::reg_idx_t wb_rd,
    input  logic                 wb_reg_write,
    input  tinker_pkg::reg_idx_t id_rs,
    input  tinker_pkg::reg_idx_t id_rt,
    input  tinker_pkg::reg_idx_t id_rd,
    input  logic                 id_uses_rt,
    input  logic                 id_valid,
    output logic [1:0]           fwd_rs,
    output logic [1:0]           fwd_rt,
    output logic [1:0]           fwd_rd,
    output logic                 load_use
);

    import tinker_pkg::*;

    // newest producer first
    function automatic logic [1:0] pick_src(reg_idx_t src, logic used);
        if (!ex_valid || !used) return fwd_none;
        if (mem_reg_write && mem_rd == src) return fwd_mem;
        if (wb_reg_write && wb_rd == src) return fwd_wb;
        return fwd_none;
    endfunction

    always_comb begin
        fwd_rs = pick_src(ex_rs, 1'b1);
        fwd_rt = pick_src(ex_rt, ex_uses_rt);
        fwd_rd = pick_src(ex_rd, 1'b1);  // rd is a source for addi, store, branches
    end

    // rs and rd compared for every opcode, a few spare bubbles at most
    assign load_use = ex_valid && ex_is_load && id_valid &&
                      (ex_rd == id_rs || ex_rd == id_rd || (id_uses_rt && ex_rd == id_rt));

    // load data only exists after the bus ack, the stall must have kept it out of EX/MEM forwarding
    a_no_load_forward: assert property (
        @(posedge clk) disable iff (reset)
        mem_is_load |-> (fwd_rs != fwd_mem && fwd_rt != fwd_mem && fwd_rd != fwd_mem)
    );

endmodule

// File: source/tinker_alu.sv
`timescale 1ns/100ps

module tinker_alu (
    input  tinker_pkg::word_t   pc,
    input  tinker_pkg::word_t   rs_val,
    input  tinker_pkg::word_t   rt_val,
    input  tinker_pkg::word_t   rd_val,
    input  tinker_pkg::word_t   literal,
    input  logic                uses_rt,
    input  tinker_pkg::opcode_t opcode,
    output tinker_pkg::word_t   result,
    output tinker_pkg::addr_t   mem_addr,
    output tinker_pkg::word_t   store_data,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                redirect,
    output tinker_pkg::word_t   target
);

    import tinker_pkg::*;

    word_t operand_b;
    word_t addr_sum;

    assign operand_b  = uses_rt ? rt_val : literal;
    assign store_data = rs_val;  // store sends rs to memory
    assign mem_addr   = addr_sum[31:0];

    always_comb begin
        result    = '0;
        addr_sum  = '0;
        reg_write = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        redirect  = 1'b0;
        target    = rd_val;  // most control flow goes to rd
        case (opcode)
            op_add:     result = rs_val + operand_b;
            op_addi:    result = rd_val + operand_b;  // rd doubles as source
            op_sub:     result = rs_val - operand_b;
            op_subi:    result = rd_val - operand_b;
            op_and:     result = rs_val & operand_b;
            op_or:      result = rs_val | operand_b;
            op_xor:     result = rs_val ^ operand_b;
            op_not:     result = ~rs_val;
            op_shftr,
            op_shftri:  result = rs_val >> operand_b;
            op_shftl,
            op_shftli:  result = rs_val << operand_b;
            op_mov_rr:  result = rs_val;
            op_mov_lit: result = {rd_val[63:12], literal[11:0]};
            op_load: begin
                addr_sum = rs_val + literal;
                mem_read = 1'b1;
            end
            op_store: begin
                addr_sum  = rd_val + literal;
                mem_write = 1'b1;
                reg_write = 1'b0;
            end
            op_jump: begin
                reg_write = 1'b0;
                redirect  = 1'b1;
            end
            op_brr_rd: begin
                reg_write = 1'b0;
                redirect  = 1'b1;
                target    = pc + rd_val;
            end
            op_brr_lit: begin
                reg_write = 1'b0;
                redirect  = 1'b1;
                target    = pc + literal;
            end
            op_brnz: begin
                reg_write = 1'b0;
                redirect  = (rs_val != '0);
            end
            op_brgt: begin
                reg_write = 1'b0;
                redirect  = ($signed(rs_val) > $signed(rt_val));
            end
            default: reg_write = 1'b0;  // halt and dropped opcodes
        endcase
    end

endmodule

// File: source/tinker_data_port.sv
`timescale 1ns/100ps

module tinker_data_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  logic              req_write,
    input  tinker_pkg::addr_t req_addr,
    input  tinker_pkg::word_t req_data,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output tinker_pkg::addr_t wb_adr,
    output tinker_pkg::word_t wb_dat_o,
    input  tinker_pkg::word_t wb_dat_i,
    input  logic              wb_ack,
    output tinker_pkg::word_t load_data,
    output logic              mem_stall
);

    logic done;   // ack seen, request leaves the memory stage this cycle
    logic start;

    assign start     = req_valid && !done && !wb_cyc;
    assign mem_stall = req_valid && !done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else if (wb_cyc && wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b1;
        end else begin
            done <= 1'b0;
            if (start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= req_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= req_addr;
            wb_dat_o <= req_data;
        end
        if (wb_cyc && wb_ack) begin
            load_data <= wb_dat_i;
        end
    end

    // classic cycle keeps the strobe and address until ack
    a_adr_stable: assert property (
        @(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr))
    );

endmodule

// File: source/tinker_core.sv
`timescale 1ns/100ps

module tinker_core (
    input  logic               clk,
    input  logic               reset,
    output tinker_pkg::word_t  imem_addr,
    input  tinker_pkg::instr_t imem_data,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output tinker_pkg::addr_t  wb_adr,
    output tinker_pkg::word_t  wb_dat_o,
    input  tinker_pkg::word_t  wb_dat_i,
    input  logic               wb_ack,
    output logic               hlt
);

    import tinker_pkg::*;

    word_t pc;
    logic  halted_fetch;  // halt has left decode
    logic  halt_done;

    logic          id_valid, ex_valid, mem_valid, wb_valid;
    fetch_stage_t  fetch_in, if_id;
    decode_stage_t id_next, id_ex;
    mem_stage_t    mem_next, ex_mem;
    wb_stage_t     wb_next, mem_wb;

    opcode_t  dec_opcode;
    reg_idx_t dec_rd, dec_rs, dec_rt;
    word_t    dec_literal;
    logic     dec_uses_rt, dec_is_halt;
    word_t    rs_val, rt_val, rd_val;

    logic [1:0] fwd_rs, fwd_rt, fwd_rd;
    logic       load_use;
    word_t      ex_rs_val, ex_rt_val, ex_rd_val;

    word_t alu_result, alu_store_data, alu_target;
    addr_t alu_addr;
    logic  alu_reg_write, alu_mem_read, alu_mem_write, alu_redirect;

    word_t load_data;
    logic  mem_stall, redirect, flush_front, fetch_stop;

    function automatic word_t fwd_pick(logic [1:0] sel, word_t reg_val, word_t mem_val,
                                       word_t wb_val);
        if (sel == fwd_mem) return mem_val;
        if (sel == fwd_wb) return wb_val;
        return reg_val;
    endfunction

    assign redirect    = ex_valid && alu_redirect;
    assign flush_front = redirect && !mem_stall;  // a stalled branch waits in EX
    assign fetch_stop  = halted_fetch || (id_valid && dec_is_halt);
    assign imem_addr   = pc;
    assign hlt         = halt_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!mem_stall) begin
            if (redirect) begin
                pc <= alu_target;
            end else if (!load_use && !fetch_stop) begin
                pc <= pc + instr_bytes;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halted_fetch <= 1'b0;
            halt_done    <= 1'b0;
        end else begin
            if (id_valid && dec_is_halt && !mem_stall && !load_use && !redirect) begin
                halted_fetch <= 1'b1;
            end
            if (mem_valid && ex_mem.opcode == op_halt && !mem_stall) begin
                halt_done <= 1'b1;  // halt enters writeback
            end
        end
    end

    // fetch
    assign fetch_in = '{pc: pc, instr: imem_data};

    tinker_stage_reg #(.payload_t(fetch_stage_t)) u_if_id (
        .clk(clk), .reset(reset), .hold(mem_stall || load_use), .flush(flush_front),
        .in_valid(!fetch_stop), .in_data(fetch_in), .out_valid(id_valid), .out_data(if_id)
    );

    // decode
    tinker_decoder u_decoder (
        .instr(if_id.instr), .opcode(dec_opcode), .rd(dec_rd), .rs(dec_rs), .rt(dec_rt),
        .literal(dec_literal), .uses_rt(dec_uses_rt), .is_halt(dec_is_halt)
    );

    tinker_regfile u_regfile (
        .clk(clk), .reset(reset), .write_en(wb_valid && mem_wb.reg_write),
        .write_idx(mem_wb.rd), .write_data(mem_wb.value),
        .read_rs(dec_rs), .read_rt(dec_rt), .read_rd(dec_rd),
        .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val)
    );

    assign id_next = '{pc: if_id.pc, opcode: dec_opcode, rd: dec_rd, rs: dec_rs, rt: dec_rt,
                       uses_rt: dec_uses_rt, rs_val: rs_val, rt_val: rt_val, rd_val: rd_val,
                       literal: dec_literal};

    tinker_stage_reg #(.payload_t(decode_stage_t)) u_id_ex (
        .clk(clk), .reset(reset), .hold(mem_stall), .flush(flush_front),
        .in_valid(id_valid && !load_use), .in_data(id_next),
        .out_valid(ex_valid), .out_data(id_ex)
    );

    // execute
    tinker_hazard u_hazard (
        .clk(clk), .reset(reset), .ex_valid(ex_valid),
        .ex_rs(id_ex.rs), .ex_rt(id_ex.rt), .ex_rd(id_ex.rd), .ex_uses_rt(id_ex.uses_rt),
        .ex_is_load(id_ex.opcode == op_load),
        .mem_rd(ex_mem.rd), .mem_reg_write(mem_valid && ex_mem.reg_write),
        .mem_is_load(mem_valid && ex_mem.mem_read),
        .wb_rd(mem_wb.rd), .wb_reg_write(wb_valid && mem_wb.reg_write),
        .id_rs(dec_rs), .id_rt(dec_rt), .id_rd(dec_rd), .id_uses_rt(dec_uses_rt),
        .id_valid(id_valid), .fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .fwd_rd(fwd_rd),
        .load_use(load_use)
    );

    assign ex_rs_val = fwd_pick(fwd_rs, id_ex.rs_val, ex_mem.result, mem_wb.value);
    assign ex_rt_val = fwd_pick(fwd_rt, id_ex.rt_val, ex_mem.result, mem_wb.value);
    assign ex_rd_val = fwd_pick(fwd_rd, id_ex.rd_val, ex_mem.result, mem_wb.value);

    tinker_alu u_alu (
        .pc(id_ex.pc), .rs_val(ex_rs_val), .rt_val(ex_rt_val), .rd_val(ex_rd_val),
        .literal(id_ex.literal), .uses_rt(id_ex.uses_rt), .opcode(id_ex.opcode),
        .result(alu_result), .mem_addr(alu_addr), .store_data(alu_store_data),
        .reg_write(alu_reg_write), .mem_read(alu_mem_read), .mem_write(alu_mem_write),
        .redirect(alu_redirect), .target(alu_target)
    );

    assign mem_next = '{opcode: id_ex.opcode, rd: id_ex.rd, reg_write: alu_reg_write,
                        mem_read: alu_mem_read, mem_write: alu_mem_write, result: alu_result,
                        address: alu_addr, store_data: alu_store_data};

    tinker_stage_reg #(.payload_t(mem_stage_t)) u_ex_mem (
        .clk(clk), .reset(reset), .hold(mem_stall), .flush(1'b0),
        .in_valid(ex_valid), .in_data(mem_next), .out_valid(mem_valid), .out_data(ex_mem)
    );

    // memory
    tinker_data_port u_data_port (
        .clk(clk), .reset(reset),
        .req_valid(mem_valid && (ex_mem.mem_read || ex_mem.mem_write)),
        .req_write(ex_mem.mem_write), .req_addr(ex_mem.address), .req_data(ex_mem.store_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .load_data(load_data), .mem_stall(mem_stall)
    );

    assign wb_next = '{rd: ex_mem.rd, reg_write: ex_mem.reg_write,
                       value: ex_mem.mem_read ? load_data : ex_mem.result};

    // writeback
    tinker_stage_reg #(.payload_t(wb_stage_t)) u_mem_wb (
        .clk(clk), .reset(reset), .hold(mem_stall), .flush(1'b0),
        .in_valid(mem_valid), .in_data(wb_next), .out_valid(wb_valid), .out_data(mem_wb)
    );

endmodule

// File: tb/tinker_program.svh
`ifndef TINKER_PROGRAM_SVH
`define TINKER_PROGRAM_SVH

// fields are opcode, rd, rs, rt, then the 12-bit literal
function automatic instr_t encode(opcode_t op, int rd, int rs, int rt, int lit);
    return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
endfunction

// everything past the program is halt
task automatic clear_program();
    for (int i = 0; i < prog_words; i++) begin
        prog[i] = encode(op_halt, 0, 0, 0, 0);
    end
    prog_len = 0;
    live     = 1'b1;
endtask

// appends one instruction, and runs it on the reference if it is on the taken path
task automatic emit_op(opcode_t op, int rd, int rs, int rt, int lit);
    prog[prog_len] = encode(op, rd, rs, rt, lit);
    prog_len++;
    if (live) begin
        exec_ref(op, rd, rs, rt, lit);
    end
endtask

task automatic load_const(int r, int value);
    emit_op(op_xor, r, r, r, 0);
    emit_op(op_mov_lit, r, 0, 0, value);
endtask

// absolute instruction address, reset_pc plus a small offset
task automatic load_addr(int r, int offset);
    emit_op(op_xor, r, r, r, 0);
    emit_op(op_mov_lit, r, 0, 0, 1);
    emit_op(op_shftli, r, r, 0, 13);  // 1 << 13 is 0x2000
    emit_op(op_addi, r, 0, 0, offset);
endtask

// next store of a live result, base r30
task automatic put_store(int r);
    emit_op(op_store, 30, r, 0, st_off);
    st_off += 8;
endtask

`endif

// File: tb/tinker_core_tb.sv
`timescale 1ns/100ps

module tinker_core_tb;

    import tinker_pkg::*;

    // five short programs, each far below 400 cycles even with 3 wait states per transfer
    localparam int     max_cycles = 4000;
    localparam int     prog_words = 256;
    localparam instr_t halt_word  = {op_halt, 27'd0};

    logic   clk, reset;
    word_t  imem_addr;
    instr_t imem_data;
    logic   wb_cyc, wb_stb, wb_we, wb_ack, hlt;
    addr_t  wb_adr;
    word_t  wb_dat_o, wb_dat_i;

    instr_t prog [prog_words];
    int     prog_len, st_off;
    word_t  imem_idx;
    logic   live;  // emitted code is on the executed path
    word_t  ref_regs [num_regs];
    word_t  exp_mem [addr_t];
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    word_t  mem [addr_t];
    addr_t  log_addr [$];
    word_t  log_data [$];
    logic [7:0] lfsr;
    logic   busy;
    int     wait_left, cycles, errors, tests;

`include "tinker_program.svh"

    tinker_core u_tinker_core (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .hlt(hlt)
    );

    always #4 clk = ~clk;

    assign imem_idx  = (imem_addr - reset_pc) >> 2;
    assign imem_data = (imem_idx < prog_words) ? prog[imem_idx[7:0]] : halt_word;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout, hlt never rose within %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // taps 8 6 5 4
    endfunction

    task automatic draw_bits(int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    function automatic word_t fill_word(addr_t a);
        return {a, ~a};
    endfunction

    task automatic complete_transfer();
        if (wb_adr[2:0] != 3'b000) begin
            errors++;
            $display("transfer to an address that is not 8-aligned: %h", wb_adr);
        end
        if (wb_we) begin
            mem[wb_adr] = wb_dat_o;
            log_addr.push_back(wb_adr);
            log_data.push_back(wb_dat_o);
        end else begin
            wb_dat_i = mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
        end
        wb_ack = 1'b1;
    endtask

    // Wishbone slave, 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;  // master drops stb at this same edge
            busy   = 1'b0;
        end else if (wb_cyc && wb_stb && !busy) begin
            if (hlt) begin
                errors++;
                $display("bus transfer started while hlt was high");
            end
            busy = 1'b1;
            draw_bits(2, wait_left);
            if (wait_left == 0) complete_transfer();
        end else if (busy) begin
            wait_left--;
            if (wait_left == 0) complete_transfer();
        end
    end

    // reference model of the kept instructions
    task automatic exec_ref(opcode_t op, int rd, int rs, int rt, int lit);
        imm_t  imm;
        word_t a, b, d, l;
        addr_t ea;
        imm = lit[11:0];
        l   = {{52{imm[11]}}, imm};
        a   = ref_regs[rs];
        d   = ref_regs[rd];
        b   = ref_uses_rt(op) ? ref_regs[rt] : l;
        case (op)
            op_add:     ref_regs[rd] = a + b;
            op_addi:    ref_regs[rd] = d + b;
            op_sub:     ref_regs[rd] = a - b;
            op_subi:    ref_regs[rd] = d - b;
            op_and:     ref_regs[rd] = a & b;
            op_or:      ref_regs[rd] = a | b;
            op_xor:     ref_regs[rd] = a ^ b;
            op_not:     ref_regs[rd] = ~a;
            op_shftr,
            op_shftri:  ref_regs[rd] = a >> b;
            op_shftl,
            op_shftli:  ref_regs[rd] = a << b;
            op_mov_rr:  ref_regs[rd] = a;
            op_mov_lit: ref_regs[rd] = {d[63:12], imm};
            op_load: begin
                ea = a + l;
                ref_regs[rd] = exp_mem.exists(ea) ? exp_mem[ea] : fill_word(ea);
            end
            op_store: begin
                ea = d + l;
                exp_mem[ea] = a;
                exp_addr.push_back(ea);
                exp_data.push_back(a);
            end
            default: ;  // control flow, halt and unknown codes leave state alone
        endcase
    endtask

    function automatic logic ref_uses_rt(opcode_t op);
        case (op)
            op_addi, op_subi, op_shftri, op_shftli, op_mov_lit,
            op_brr_lit, op_load, op_store: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic ref_taken(opcode_t op, word_t a, word_t b);
        case (op)
            op_brnz: return a != '0;
            op_brgt: return $signed(a) > $signed(b);
            default: return 1'b1;
        endcase
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic start_test();
        mem.delete();
        exp_mem.delete();
        exp_addr.delete();
        exp_data.delete();
        log_addr.delete();
        log_data.delete();
        for (int i = 0; i < num_regs; i++) ref_regs[i] = '0;
        st_off = 0;
        clear_program();
    endtask

    task automatic reset_dut();
        reset  = 1'b1;
        wb_ack = 1'b0;
        busy   = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic run_program(string name);
        int errs_before;
        errs_before = errors;
        reset_dut();
        check_bit("hlt", hlt, 1'b0);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_bit("wb_we", wb_we, 1'b0);
        check_word("imem_addr", imem_addr, reset_pc);
        while (hlt !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (12) @(posedge clk);  // idle bus expected from here on
        #1;
        if (hlt !== 1'b1) begin
            errors++;
            $display("hlt dropped after it rose");
        end
        if (log_addr.size() != exp_addr.size()) begin
            errors++;
            $display("%0d stores seen, %0d expected", log_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
            check_addr("wb_adr", log_addr[i], exp_addr[i]);
            check_word("wb_dat_o", log_data[i], exp_data[i]);
        end
        tests++;
        $display("test %s: %s", name, errors == errs_before ? "ok" : "mismatch");
    endtask

    task automatic test_alu_chain();
        start_test();
        load_const(30, 'h100);
        load_const(1, 'h5a5);
        load_const(2, 'h0f3);
        load_const(10, 4);
        emit_op(op_add, 3, 1, 2, 0);
        put_store(3);
        emit_op(op_sub, 4, 3, 1, 0);
        emit_op(op_and, 5, 4, 2, 0);
        put_store(5);
        emit_op(op_or, 6, 5, 1, 0);
        emit_op(op_xor, 7, 6, 3, 0);
        emit_op(op_not, 8, 7, 0, 0);
        put_store(8);
        emit_op(op_shftr, 9, 1, 10, 0);
        emit_op(op_shftl, 11, 2, 10, 0);
        emit_op(op_shftri, 12, 3, 0, 3);
        emit_op(op_shftli, 13, 4, 0, 5);
        put_store(9);
        put_store(11);
        put_store(12);
        put_store(13);
        emit_op(op_mov_rr, 14, 13, 0, 0);
        emit_op(op_mov_lit, 14, 0, 0, 'h7ff);  // keeps the upper bits of r14
        emit_op(op_addi, 14, 0, 0, 100);
        emit_op(op_subi, 13, 0, 0, -3);
        put_store(14);
        put_store(13);
        emit_op(op_add, 16, 1, 2, 0);  // consumer three slots later reads through the regfile
        emit_op(op_or, 17, 1, 1, 0);
        emit_op(op_or, 18, 2, 2, 0);
        emit_op(op_sub, 19, 16, 1, 0);
        put_store(19);
        emit_op(op_halt, 0, 0, 0, 0);
        run_program("alu_chain");
    endtask

    task automatic test_load_use();
        start_test();
        load_const(30, 'h200);
        load_const(5, 'h123);
        put_store(5);
        emit_op(op_load, 6, 30, 0, 0);
        emit_op(op_add, 7, 6, 6, 0);
        put_store(7);
        emit_op(op_load, 8, 30, 0, 8);
        put_store(8);
        emit_op(op_halt, 0, 0, 0, 0);
        run_program("load_use");
    endtask

    // two stores that only run if the branch falls through
    task automatic wrong_path(logic taken);
        live = !taken;
        emit_op(op_store, 30, 7, 0, 'h400);
        emit_op(op_store, 30, 7, 0, 'h408);
        live = 1'b1;
    endtask

    task automatic branch_skip(opcode_t op, int rs, int rt);
        int   idx;
        logic taken;
        idx = prog_len + 4;  // branch follows the four address instructions
        load_addr(1, 4 * (idx + 3));
        taken = ref_taken(op, ref_regs[rs], ref_regs[rt]);
        emit_op(op, 1, rs, rt, 0);
        wrong_path(taken);
        put_store(5);
    endtask

    task automatic test_branches();
        start_test();
        load_const(30, 'h100);
        load_const(5, 'h11);
        load_const(7, 'h77);
        load_const(9, 0);
        load_const(3, 0);
        emit_op(op_subi, 3, 0, 0, 5);
        load_const(4, 0);
        emit_op(op_subi, 4, 0, 0, 9);
        branch_skip(op_jump, 0, 0);
        load_const(2, 12);
        emit_op(op_brr_rd, 2, 0, 0, 0);
        wrong_path(1'b1);
        put_store(5);
        emit_op(op_brr_lit, 0, 0, 0, 12);
        wrong_path(1'b1);
        put_store(5);
        branch_skip(op_brnz, 5, 0);
        branch_skip(op_brnz, 9, 0);
        branch_skip(op_brgt, 3, 4);  // -5 > -9
        branch_skip(op_brgt, 4, 3);
        emit_op(op_halt, 0, 0, 0, 0);
        run_program("branches");
    endtask

    task automatic test_wait_states();
        start_test();
        load_const(30, 'h300);
        load_const(5, 1);
        for (int i = 0; i < 16; i++) begin
            emit_op(op_addi, 5, 0, 0, i * 7 + 1);
            put_store(5);
        end
        emit_op(op_halt, 0, 0, 0, 0);
        run_program("wait_states");
    endtask

    task automatic test_halt();
        start_test();
        load_const(30, 'h400);
        load_const(5, 'h42);
        put_store(5);
        emit_op(opcode_t'(5'b11111), 5, 5, 5, 'hfff);
        emit_op(opcode_t'(5'b01100), 5, 5, 5, 0);
        put_store(5);
        emit_op(op_halt, 0, 0, 0, 0);
        live = 1'b0;
        put_store(5);  // past halt, never fetched
        live = 1'b1;
        run_program("halt");
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        wb_dat_i = '0;
        wb_ack   = 1'b0;
        busy     = 1'b0;
        lfsr     = 8'd63;
        cycles   = 0;
        errors   = 0;
        tests    = 0;
        clear_program();
        test_alu_chain();
        test_load_use();
        test_branches();
        test_wait_states();
        test_halt();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tb
source/tinker_pkg.sv
source/tinker_stage_reg.sv
source/tinker_decoder.sv
source/tinker_regfile.sv
source/tinker_hazard.sv
source/tinker_alu.sv
source/tinker_data_port.sv
source/tinker_core.sv
tb/tinker_core_tb.sv
